// File: design/mem_consts.svh
// Memory map constants
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data and address widths
`define MEM_BITS 16
`define MEM_ADDR_BITS 16

// RAM banks, selected by the top address bits
`define MEM_BANKS 4

// boot ROM index width, 256 words
`define ROM_ADDR_BITS 8

// peripheral pages, upper 12 address bits
`define GPIO_PAGE 12'h011 // 0x011x
`define PWM_PAGE 12'h012 // 0x012x

`endif

// File: design/mem_pkg.sv
// Memory controller types
`include "mem_consts.svh"

package mem_pkg;

	// I/O view of an address
	typedef struct packed {
		logic [`MEM_ADDR_BITS-5:0] page; // 16-word page
		logic [3:0] idx; // register index
	} ioAddr_t;

	// RAM view of the same address
	typedef struct packed {
		logic [$clog2(`MEM_BANKS)-1:0] bank;
		logic [`MEM_ADDR_BITS-3:0] offset;
	} ramAddr_t;

	typedef union packed {
		ioAddr_t io;
		ramAddr_t ram;
	} memAddr_u;

	// request to a peripheral register block
	typedef struct packed {
		logic [3:0] idx;
		logic [`MEM_BITS-1:0] wdata;
		logic wr; // single-cycle strobe
	} regReq_t;

	// request to one RAM bank
	typedef struct packed {
		logic [`MEM_ADDR_BITS-3:0] offset;
		logic [`MEM_BITS-1:0] wdata;
		logic wr;
	} ramReq_t;

	// fixed boot image, scrambled index pattern
	function automatic logic [`MEM_BITS-1:0] romWord(input logic [`ROM_ADDR_BITS-1:0] idx);
		logic [`MEM_BITS-1:0] w;
		w = {idx, ~idx} ^ 16'hC35A;
		w = {w[12:0], w[15:13]}; // rotate left by 3
		return w + {8'h00, idx};
	endfunction

endpackage

// File: design/boot_rom.sv
// Boot ROM
`timescale 1ns/1ps
`include "mem_consts.svh"

module boot_rom (
	input logic CLK,
	input logic [`ROM_ADDR_BITS-1:0] idx,
	output logic [`MEM_BITS-1:0] rdata
);

	import mem_pkg::*;

	localparam int DEPTH = 1 << `ROM_ADDR_BITS;

	logic [`MEM_BITS-1:0] romTable [DEPTH];

	// image comes from the shared content function
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			romTable[i] = romWord(`ROM_ADDR_BITS'(i));
		end
	end

	// synchronous read, one cycle latency
	always_ff @(posedge CLK) begin
		rdata <= romTable[idx];
	end

endmodule

// File: design/ram_bank.sv
// Single-port RAM bank
`timescale 1ns/1ps
`include "mem_consts.svh"

module ram_bank #(
	parameter int OFFSET_BITS = 14
) (
	input logic CLK,
	input mem_pkg::ramReq_t req,
	output logic [`MEM_BITS-1:0] rdata
);

	logic [`MEM_BITS-1:0] mem [1 << OFFSET_BITS];
	logic [OFFSET_BITS-1:0] addr;

	assign addr = req.offset[OFFSET_BITS-1:0];

	// read returns the old word when a write hits the same address
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

	always_ff @(posedge CLK) begin
		if (req.wr) begin
			mem[addr] <= req.wdata;
		end
	end

endmodule

// File: design/gpio_port.sv
// GPIO register block
`timescale 1ns/1ps
`include "mem_consts.svh"

module gpio_port (
	input logic CLK,
	input logic RSTb,
	input mem_pkg::regReq_t req,
	output logic [`MEM_BITS-1:0] rdata,
	output logic [3:0] outPins,
	input logic [5:0] inPins
);

	logic [3:0] outLatch;
	logic [5:0] inMeta;
	logic [5:0] inSync;

	// output latch, register 0
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			outLatch <= 4'h0;
		end else if (req.wr && req.idx == 4'd0) begin
			outLatch <= req.wdata[3:0];
		end
	end

	assign outPins = outLatch;

	// two-flop synchronizer on the input pins
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			inMeta <= 6'h00;
			inSync <= 6'h00;
		end else begin
			inMeta <= inPins; // may go metastable
			inSync <= inMeta;
		end
	end

	// read port, no side effects
	always_comb begin
		case (req.idx)
			4'd0: begin
				rdata = {{(`MEM_BITS-4){1'b0}}, outLatch};
			end
			4'd1: begin
				rdata = {{(`MEM_BITS-6){1'b0}}, inSync};
			end
			default: begin
				rdata = '0; // unused registers
			end
		endcase
	end

endmodule

// File: design/pwm_led.sv
// Three-channel PWM LED driver
`timescale 1ns/1ps
`include "mem_consts.svh"

module pwm_led (
	input logic CLK,
	input logic RSTb,
	input mem_pkg::regReq_t req,
	output logic [`MEM_BITS-1:0] rdata,
	output logic [2:0] ledPins
);

	logic [2:0][7:0] duty;
	logic [7:0] count;

	// duty registers 0 to 2
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty <= '0;
		end else if (req.wr && req.idx < 4'd3) begin
			duty[req.idx[1:0]] <= req.wdata[7:0];
		end
	end

	// free-running period counter, wraps at 255
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count <= 8'h00;
		end else begin
			count <= count + 8'd1;
		end
	end

	// one compare per channel, registered
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ledPins <= 3'b000;
		end else begin
			for (int i = 0; i < 3; i++) begin
				ledPins[i] <= (count < duty[i]);
			end
		end
	end

	always_comb begin
		case (req.idx)
			4'd0, 4'd1, 4'd2: begin
				rdata = {{(`MEM_BITS-8){1'b0}}, duty[req.idx[1:0]]};
			end
			4'd3: begin
				rdata = {{(`MEM_BITS-8){1'b0}}, count}; // counter snapshot
			end
			default: begin
				rdata = '0;
			end
		endcase
	end

endmodule

// File: design/memory_controller.sv
// Memory controller top
`timescale 1ns/1ps
`include "mem_consts.svh"

module memory_controller (
	input logic CLK,
	input logic RSTb,
	input mem_pkg::memAddr_u ADDRESS,
	input logic [`MEM_BITS-1:0] DATA_IN,
	input logic memWR,
	output logic [`MEM_BITS-1:0] DATA_OUT,
	output logic [6:0] PINS,
	input logic [5:0] INPUT_PINS
);

	import mem_pkg::*;

	regReq_t regReq;
	regReq_t gpioReq;
	regReq_t pwmReq;
	ramReq_t ramReq;

	logic wrGpio;
	logic wrPwm;
	logic [`MEM_BANKS-1:0] wrBank;

	logic [`MEM_BITS-1:0] romData;
	logic [`MEM_BITS-1:0] gpioData;
	logic [`MEM_BITS-1:0] pwmData;
	logic [`MEM_BITS-1:0] bankData [`MEM_BANKS];

	logic [`MEM_BITS-1:0] periphNext;
	logic [`MEM_BITS-1:0] periphQ;
	memAddr_u addrQ;

	// shared requests, built from both address views
	assign regReq = '{idx: ADDRESS.io.idx, wdata: DATA_IN, wr: memWR};
	assign ramReq = '{offset: ADDRESS.ram.offset, wdata: DATA_IN, wr: memWR};

	// one-hot write strobes, at most one target per cycle
	always_comb begin
		wrGpio = 1'b0;
		wrPwm = 1'b0;
		wrBank = '0;
		case (ADDRESS.io.page)
			`GPIO_PAGE: begin
				wrGpio = regReq.wr;
			end
			`PWM_PAGE: begin
				wrPwm = regReq.wr;
			end
			default: begin
				wrBank[ADDRESS.ram.bank] = ramReq.wr; // includes the ROM window
			end
		endcase
	end

	assign gpioReq = '{idx: regReq.idx, wdata: regReq.wdata, wr: wrGpio};
	assign pwmReq = '{idx: regReq.idx, wdata: regReq.wdata, wr: wrPwm};

	// peripheral word to capture; other pages keep the old one
	always_comb begin
		case (ADDRESS.io.page)
			`GPIO_PAGE: begin
				periphNext = gpioData;
			end
			`PWM_PAGE: begin
				periphNext = pwmData;
			end
			default: begin
				periphNext = periphQ;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			periphQ <= '0;
			addrQ <= '0;
		end else begin
			periphQ <= periphNext;
			addrQ <= ADDRESS;
		end
	end

	// ROM and banks are already registered, so they line up with periphQ
	always_comb begin
		case (addrQ.io.page[11:4])
			8'h00: begin
				DATA_OUT = romData;
			end
			8'h01, 8'h02, 8'h03, 8'h04, 8'h05: begin
				DATA_OUT = periphQ; // I/O window
			end
			default: begin
				DATA_OUT = bankData[addrQ.ram.bank];
			end
		endcase
	end

	boot_rom theRom (
		.CLK(CLK),
		.idx(ADDRESS[`ROM_ADDR_BITS-1:0]),
		.rdata(romData)
	);

	for (genvar b = 0; b < `MEM_BANKS; b++) begin : bankGen
		ramReq_t bankReq;

		assign bankReq = '{offset: ramReq.offset, wdata: ramReq.wdata, wr: wrBank[b]};

		ram_bank #(
			.OFFSET_BITS(`MEM_ADDR_BITS-2)
		) theRam (
			.CLK(CLK),
			.req(bankReq),
			.rdata(bankData[b])
		);
	end

	gpio_port g0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.req(gpioReq),
		.rdata(gpioData),
		.outPins(PINS[3:0]),
		.inPins(INPUT_PINS)
	);

	pwm_led led0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.req(pwmReq),
		.rdata(pwmData),
		.ledPins(PINS[6:4])
	);

endmodule

// File: tests/memory_controller_chk.sv
// Memory controller assertions
`timescale 1ns/1ps
`include "mem_consts.svh"

module memory_controller_chk (
	input logic CLK,
	input logic RSTb,
	input logic wrGpio,
	input logic wrPwm,
	input logic [`MEM_BANKS-1:0] wrBank,
	input logic [6:0] PINS,
	input logic [`MEM_BITS-1:0] DATA_OUT,
	input mem_pkg::memAddr_u ADDRESS,
	input logic [`MEM_BITS-1:0] gpioData,
	input logic [`MEM_BITS-1:0] pwmData,
	input logic [`MEM_BITS-1:0] bankData [`MEM_BANKS]
);

	import mem_pkg::*;

	oneStrobe: assert property (@(posedge CLK) $onehot0({wrGpio, wrPwm, wrBank}))
		else $error("more than one write strobe active in one cycle");

	pinsAfterReset: assert property (@(posedge CLK) $rose(RSTb) |-> PINS == 7'h00)
		else $error("PINS not zero right after reset");

	// word on DATA_OUT comes from the address sampled one edge earlier
	readRom: assert property (@(posedge CLK) disable iff (!RSTb)
		(ADDRESS.io.page[11:4] == 8'h00) |=>
		DATA_OUT == romWord($past(ADDRESS[`ROM_ADDR_BITS-1:0])))
		else $error("ROM read returned the wrong word");

	readPeriph: assert property (@(posedge CLK) disable iff (!RSTb)
		(ADDRESS.io.page == `GPIO_PAGE || ADDRESS.io.page == `PWM_PAGE) |=>
		DATA_OUT == $past(ADDRESS.io.page == `GPIO_PAGE ? gpioData : pwmData))
		else $error("peripheral read returned the wrong word");

	// unwritten RAM reads are X on both sides
	readBank: assert property (@(posedge CLK) disable iff (!RSTb)
		(ADDRESS.io.page[11:4] > 8'h05) |=>
		DATA_OUT === bankData[$past(ADDRESS.ram.bank)])
		else $error("RAM read did not return the word of the addressed bank");

endmodule

bind memory_controller memory_controller_chk chk_i (
	.CLK(CLK),
	.RSTb(RSTb),
	.wrGpio(wrGpio),
	.wrPwm(wrPwm),
	.wrBank(wrBank),
	.PINS(PINS),
	.DATA_OUT(DATA_OUT),
	.ADDRESS(ADDRESS),
	.gpioData(gpioData),
	.pwmData(pwmData),
	.bankData(bankData)
);

// File: tests/memory_controller_tb.sv
// Memory controller testbench
`timescale 1ns/1ps
`include "mem_consts.svh"

module memory_controller_tb;

	import mem_pkg::*;

	logic CLK;
	logic RSTb;
	memAddr_u ADDRESS;
	logic [`MEM_BITS-1:0] DATA_IN;
	logic memWR;
	logic [5:0] INPUT_PINS;
	logic [`MEM_BITS-1:0] DATA_OUT;
	logic [6:0] PINS;

	// read pipeline, one stage behind issue
	logic issueValid;
	logic [`MEM_BITS-1:0] issueExp;
	logic chkValid;
	logic [`MEM_BITS-1:0] chkExp;

	// model state
	logic [`MEM_BITS-1:0] ramModel [logic [`MEM_ADDR_BITS-1:0]];
	logic [3:0] gpioModel;
	logic [5:0] inputModel;
	logic [7:0] dutyModel [3];

	logic [31:0] lfsrState;
	memAddr_u ramAddrs [$];

	memory_controller dut_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.memWR(memWR),
		.DATA_OUT(DATA_OUT),
		.PINS(PINS),
		.INPUT_PINS(INPUT_PINS)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// expected DATA_OUT for a read of address a
	function automatic logic [`MEM_BITS-1:0] expectRead(input memAddr_u a);
		if (a.io.page[11:4] == 8'h00) begin
			return romWord(a[`ROM_ADDR_BITS-1:0]);
		end else if (a.io.page == `GPIO_PAGE) begin
			return (a.io.idx == 4'd0) ? {12'h000, gpioModel} : {10'h000, inputModel};
		end else if (a.io.page == `PWM_PAGE) begin
			return {8'h00, dutyModel[a.io.idx[1:0]]};
		end
		return ramModel[a];
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [`MEM_BITS-1:0] got,
			input logic [`MEM_BITS-1:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkPins(input string name, input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic writeWord(input memAddr_u a, input logic [`MEM_BITS-1:0] d);
		@(posedge CLK);
		ADDRESS <= a;
		DATA_IN <= d;
		memWR <= 1'b1;
		issueValid <= 1'b0;
		if (a.io.page == `GPIO_PAGE) begin
			if (a.io.idx == 4'd0) begin
				gpioModel = d[3:0];
			end
		end else if (a.io.page == `PWM_PAGE) begin
			if (a.io.idx < 4'd3) begin
				dutyModel[a.io.idx[1:0]] = d[7:0];
			end
		end else begin
			ramModel[a] = d; // ROM window writes land in bank 0
		end
	endtask

	task automatic readWord(input memAddr_u a);
		@(posedge CLK);
		ADDRESS <= a;
		memWR <= 1'b0;
		issueValid <= 1'b1;
		issueExp <= expectRead(a);
	endtask

	task automatic idleCycle();
		@(posedge CLK);
		memWR <= 1'b0;
		issueValid <= 1'b0;
	endtask

	// compare stage
	always @(posedge CLK) begin
		chkValid <= issueValid;
		chkExp <= issueExp;
	end

	always @(negedge CLK) begin
		if (chkValid) begin
			checkWord("DATA_OUT", DATA_OUT, chkExp);
		end
	end

	initial begin
		memAddr_u a;
		logic [5:0] pinsIn;
		int cycles;
		int highs [3];

		lfsrState = 32'd95516;
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		memWR = 1'b0;
		INPUT_PINS = '0;
		issueValid = 1'b0;
		issueExp = '0;
		chkValid = 1'b0;
		chkExp = '0;
		gpioModel = '0;
		inputModel = '0;
		dutyModel = '{8'h00, 8'h00, 8'h00};
		repeat (8) @(posedge CLK);
		RSTb <= 1'b1;

		@(negedge CLK);
		checkPins("PINS", PINS, 7'h00);
		readWord('0);

		// back-to-back ROM reads
		for (int i = 0; i < 64; i++) begin
			a = '0;
			a[7:0] = 8'(randBits(8));
			readWord(a);
		end

		// RAM writes over all banks, clear of the ROM and I/O windows
		for (int i = 0; i < 48; i++) begin
			a.ram.bank = 2'(i);
			a.ram.offset = 14'(randBits(14));
			if (a < 16'h0600) begin
				a = a | 16'h1000;
			end
			writeWord(a, 16'(randBits(16)));
			ramAddrs.push_back(a);
		end
		a = 16'h1000 | 16'(randBits(12));
		writeWord(a, 16'(randBits(16)));
		ramAddrs.push_back(a);
		a = '0;
		a[7:0] = 8'(randBits(8));
		writeWord(a, 16'(randBits(16)));
		readWord(a); // still ROM
		foreach (ramAddrs[i]) begin
			readWord(ramAddrs[i]);
		end

		// GPIO output latch
		a = '0;
		a.io.page = `GPIO_PAGE;
		writeWord(a, 16'(randBits(16)));
		idleCycle();
		@(negedge CLK);
		checkPins("PINS", PINS, {3'b000, gpioModel});
		readWord(a);
		idleCycle();

		// GPIO inputs through the synchronizer
		a.io.idx = 4'd1;
		pinsIn = 6'h20 | 6'(randBits(5));
		@(posedge CLK);
		ADDRESS <= a;
		INPUT_PINS <= pinsIn;
		inputModel = pinsIn;
		issueValid <= 1'b0;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			@(negedge CLK);
		end while (DATA_OUT !== expectRead(a) && cycles < 3);
		if (DATA_OUT !== expectRead(a)) begin
			abortRun("GPIO input pins did not reach register 1 within 3 cycles");
		end

		// PWM duties, readback and duty cycle
		a = '0;
		a.io.page = `PWM_PAGE;
		for (int c = 0; c < 3; c++) begin
			a.io.idx = 4'(c);
			writeWord(a, 16'(randBits(16)));
		end
		for (int c = 0; c < 3; c++) begin
			a.io.idx = 4'(c);
			readWord(a);
		end
		idleCycle();
		idleCycle();
		highs = '{0, 0, 0};
		repeat (256) begin
			@(negedge CLK);
			for (int c = 0; c < 3; c++) begin
				highs[c] += PINS[4 + c];
			end
		end
		for (int c = 0; c < 3; c++) begin
			checkWord("PWM high count", 16'(highs[c]), {8'h00, dutyModel[c]});
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/mem_pkg.sv
design/boot_rom.sv
design/ram_bank.sv
design/gpio_port.sv
design/pwm_led.sv
design/memory_controller.sv
tests/memory_controller_chk.sv
tests/memory_controller_tb.sv
